// File: Makefile
# Verilator build and run for the issue subsystem testbench
VERILATOR ?= verilator
TOP       ?= issue_subsystem_tb
FILELIST  ?= issue_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: issue_subsystem.f
verilog/issue_pkg.sv
verilog/regfile.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/scoreboard.sv
verilog/operand_read.sv
verilog/commit_unit.sv
verilog/issue_subsystem.sv
verification/issue_subsystem_props.sv
verification/issue_subsystem_tb.sv

// File: verification/issue_subsystem_props.sv
// scoreboard checks, bound into every scoreboard instance and idle while rst_ni is low
`timescale 1ns/1ps

module issue_subsystem_props (
    input logic           clk_i,
    input logic           rst_ni,
    input logic           issue_valid_i,
    input logic           issue_ack_i,
    input logic           full_i,
    input logic           commit_ack_i,
    input logic           head_valid_i,
    input issue_pkg::fu_t x0_clobber_i
);

    // x0 can never be owned by a unit
    x0_never_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        x0_clobber_i == issue_pkg::FU_NONE)
        else $error("x0 has an owner in the clobber table");

    // retire only with a result present
    commit_has_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
        commit_ack_i |-> head_valid_i)
        else $error("commit of a head entry without a result");

    issue_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_ack_i |-> issue_valid_i)
        else $error("issue ack without issue valid");

    // a full ring takes nothing new
    full_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
        full_i |-> !issue_ack_i)
        else $error("issue ack while the scoreboard is full");

endmodule

bind scoreboard issue_subsystem_props props0 (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_valid_i (issue_valid_o),
    .issue_ack_i   (issue_ack_i),
    .full_i        (full_o),
    .commit_ack_i  (commit_ack_i),
    .head_valid_i  (commit_instr_o.valid),
    .x0_clobber_i  (rd_clobber_o[0])
);

// File: verification/issue_subsystem_tb.sv
// commits are expected strictly in program order, killed rows must follow a drained pipeline
`timescale 1ns/1ps

module issue_subsystem_tb;

    typedef enum logic [1:0] {
        ROW_INSTR,
        ROW_KILL,
        ROW_FLUSH
    } row_kind_t;

    // one stimulus row, kill rows are issued and then flushed
    typedef struct packed {
        logic [2:0]        test;
        row_kind_t         kind;
        issue_pkg::instr_t instr;
    } row_t;

    logic               clk_i;
    logic               rst_ni;
    logic               flush_i;
    logic               decoded_valid_i;
    issue_pkg::instr_t  decoded_instr_i;
    logic               decoded_ack_o;
    logic               full_o;
    logic               commit_valid_o;
    issue_pkg::commit_t commit_o;

    row_t               rows [$];
    // expected commits in program order, with the test each belongs to
    issue_pkg::commit_t exp_q [$];
    int                 exp_test_q [$];
    logic [31:0]        model_rf [32];
    string              test_names [6];
    int                 test_commits [6];
    int                 test_errors [6];
    int                 cur_test;
    int                 error_count;
    int                 seed;
    int                 watchdog_cycles;
    bit                 full_seen;

    issue_subsystem dut0 (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .decoded_valid_i (decoded_valid_i),
        .decoded_instr_i (decoded_instr_i),
        .decoded_ack_o   (decoded_ack_o),
        .full_o          (full_o),
        .commit_valid_o  (commit_valid_o),
        .commit_o        (commit_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // --------------------
    // reference model
    // --------------------
    function automatic logic [31:0] ref_result(input issue_pkg::alu_op_t op,
                                               input logic [31:0] a, input logic [31:0] b);
        case (op)
            issue_pkg::ADD: return a + b;
            issue_pkg::SUB: return a - b;
            issue_pkg::AND: return a & b;
            issue_pkg::OR:  return a | b;
            issue_pkg::XOR: return a ^ b;
            issue_pkg::SLL: return a << b[4:0];
            // low half of the product
            issue_pkg::MUL: return a * b;
            default:        return '0;
        endcase
    endfunction

    task automatic model_issue(input int test, input issue_pkg::instr_t ins);
        logic [31:0]        a;
        logic [31:0]        b;
        issue_pkg::commit_t c;
        a        = model_rf[ins.rs1];
        b        = ins.use_imm ? ins.imm : model_rf[ins.rs2];
        c.rd     = ins.rd;
        c.result = ref_result(ins.op, a, b);
        // x0 commits but keeps reading zero
        if (ins.rd != 5'd0) begin
            model_rf[ins.rd] = c.result;
        end
        exp_q.push_back(c);
        exp_test_q.push_back(test);
    endtask

    // --------------------
    // table building
    // --------------------
    task automatic push_row(input int test, input row_kind_t kind, input issue_pkg::fu_t fu,
                            input issue_pkg::alu_op_t op, input int rd, input int rs1,
                            input int rs2, input logic use_imm, input logic [31:0] imm);
        row_t r;
        r.test          = 3'(test);
        r.kind          = kind;
        r.instr.fu      = fu;
        r.instr.op      = op;
        r.instr.rd      = 5'(rd);
        r.instr.rs1     = 5'(rs1);
        r.instr.rs2     = 5'(rs2);
        r.instr.use_imm = use_imm;
        r.instr.imm     = imm;
        rows.push_back(r);
    endtask

    task automatic alu_rr(input int test, input issue_pkg::alu_op_t op,
                          input int rd, input int rs1, input int rs2);
        push_row(test, ROW_INSTR, issue_pkg::FU_ALU, op, rd, rs1, rs2, 1'b0, 32'd0);
    endtask

    task automatic alu_ri(input int test, input issue_pkg::alu_op_t op,
                          input int rd, input int rs1, input logic [31:0] imm);
        push_row(test, ROW_INSTR, issue_pkg::FU_ALU, op, rd, rs1, 0, 1'b1, imm);
    endtask

    task automatic mul_rr(input int test, input int rd, input int rs1, input int rs2);
        push_row(test, ROW_INSTR, issue_pkg::FU_MUL, issue_pkg::MUL, rd, rs1, rs2, 1'b0, 32'd0);
    endtask

    task automatic build_table();
        // random seeds for x1..x4
        for (int r = 1; r <= 4; r++) begin
            alu_ri(0, issue_pkg::ADD, r, 0, $random(seed));
        end
        alu_rr(0, issue_pkg::SUB, 5, 1, 2);
        alu_rr(0, issue_pkg::AND, 6, 3, 4);
        alu_rr(0, issue_pkg::OR, 7, 1, 4);
        alu_rr(0, issue_pkg::XOR, 8, 2, 3);
        alu_rr(0, issue_pkg::SLL, 9, 1, 2);
        // each result feeds the next
        alu_rr(1, issue_pkg::ADD, 10, 1, 2);
        alu_rr(1, issue_pkg::ADD, 11, 10, 3);
        alu_rr(1, issue_pkg::SUB, 12, 11, 10);
        alu_rr(1, issue_pkg::XOR, 13, 12, 11);
        alu_ri(1, issue_pkg::SLL, 14, 13, 32'd3);
        // slow multiply at the head, alu results queue up behind it and fill the ring
        mul_rr(2, 15, 1, 2);
        alu_rr(2, issue_pkg::ADD, 16, 3, 4);
        alu_rr(2, issue_pkg::OR, 17, 5, 6);
        alu_rr(2, issue_pkg::AND, 18, 7, 8);
        alu_rr(2, issue_pkg::XOR, 19, 9, 3);
        mul_rr(2, 20, 15, 16);
        alu_ri(2, issue_pkg::ADD, 21, 20, 32'd1);
        // same rd twice, readers must see the later write
        alu_rr(3, issue_pkg::ADD, 22, 1, 2);
        mul_rr(3, 22, 3, 4);
        alu_rr(3, issue_pkg::ADD, 23, 22, 0);
        mul_rr(3, 24, 1, 1);
        alu_ri(3, issue_pkg::ADD, 24, 2, 32'd5);
        alu_rr(3, issue_pkg::SUB, 25, 24, 1);
        alu_rr(4, issue_pkg::ADD, 0, 1, 2);
        alu_ri(4, issue_pkg::ADD, 26, 0, 32'd7);
        alu_rr(4, issue_pkg::OR, 27, 0, 3);
        mul_rr(4, 0, 3, 4);
        alu_rr(4, issue_pkg::ADD, 26, 0, 26);
        // x28 and x29 are written only by killed rows
        push_row(5, ROW_KILL, issue_pkg::FU_MUL, issue_pkg::MUL, 28, 1, 2, 1'b0, 32'd0);
        push_row(5, ROW_KILL, issue_pkg::FU_ALU, issue_pkg::ADD, 29, 3, 4, 1'b0, 32'd0);
        push_row(5, ROW_FLUSH, issue_pkg::FU_NONE, issue_pkg::ADD, 0, 0, 0, 1'b0, 32'd0);
        alu_ri(5, issue_pkg::ADD, 30, 28, 32'd1);
        alu_rr(5, issue_pkg::ADD, 31, 29, 1);
    endtask

    // --------------------
    // drive helpers
    // --------------------
    // hold the row from a rising edge until ack is seen mid-cycle
    task automatic send(input issue_pkg::instr_t ins);
        @(posedge clk_i);
        decoded_valid_i <= 1'b1;
        decoded_instr_i <= ins;
        @(negedge clk_i);
        while (!decoded_ack_o) begin
            @(negedge clk_i);
        end
    endtask

    task automatic idle();
        @(posedge clk_i);
        decoded_valid_i <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic finish_test(input int test);
        idle();
        wait_drain();
        $display("test %0d %s: %0d commits, %0d errors", test, test_names[test],
                 test_commits[test], test_errors[test]);
    endtask

    // --------------------
    // commit monitor
    // --------------------
    // outputs settle in the second half of the cycle
    initial begin : commit_monitor
        issue_pkg::commit_t want;
        int                 t;
        forever begin
            @(negedge clk_i);
            if (rst_ni && full_o) begin
                full_seen = 1'b1;
            end
            if (rst_ni && commit_valid_o) begin
                if (exp_q.size() == 0) begin
                    $display("error in test %s: commit of x%0d with nothing outstanding",
                             test_names[cur_test], commit_o.rd);
                    error_count++;
                    test_errors[cur_test]++;
                end else begin
                    want = exp_q.pop_front();
                    t    = exp_test_q.pop_front();
                    test_commits[t]++;
                    if (commit_o !== want) begin
                        $display("mismatch %s: expected x%0d=%08h, actual x%0d=%08h",
                                 test_names[t], want.rd, want.result,
                                 commit_o.rd, commit_o.result);
                        error_count++;
                        test_errors[t]++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin : main
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        decoded_valid_i = 1'b0;
        decoded_instr_i = '0;
        seed            = 95960;
        error_count     = 0;
        cur_test        = 0;
        full_seen       = 1'b0;
        test_names      = '{"alu_indep", "raw_chain", "mul_ooo", "waw", "x0_write", "flush"};
        for (int r = 0; r < 32; r++) begin
            model_rf[r] = '0;
        end
        for (int k = 0; k < 6; k++) begin
            test_commits[k] = 0;
            test_errors[k]  = 0;
        end
        build_table();
        watchdog_cycles = rows.size() * 12 + 50;

        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            if (int'(rows[i].test) != cur_test) begin
                finish_test(cur_test);
                cur_test = int'(rows[i].test);
            end
            case (rows[i].kind)
                ROW_INSTR: begin
                    model_issue(cur_test, rows[i].instr);
                    send(rows[i].instr);
                end
                ROW_KILL: begin
                    // older work must retire before it can be flushed away
                    if (exp_q.size() != 0) begin
                        idle();
                        wait_drain();
                    end
                    send(rows[i].instr);
                end
                default: begin
                    // flush lands on the edge after the last killed issue
                    @(posedge clk_i);
                    decoded_valid_i <= 1'b0;
                    flush_i         <= 1'b1;
                    @(posedge clk_i);
                    flush_i <= 1'b0;
                    // quiet window where a stray commit would show up
                    repeat (6) @(posedge clk_i);
                end
            endcase
        end
        finish_test(cur_test);

        if (!full_seen) begin
            $display("error: scoreboard never reported full during the run");
            error_count++;
        end
        $display("summary: 6 tests, %0d rows, %0d errors", rows.size(), error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: verilog/alu_unit.sv
// one cycle latency, accepts a request every cycle, MUL is not handled here
`timescale 1ns/1ps

module alu_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  issue_pkg::fu_req_t req_i,
    output issue_pkg::wb_t     wb_o
);

    logic [issue_pkg::XLEN-1:0]          result;
    logic                                valid_q;
    logic [issue_pkg::TRANS_ID_BITS-1:0] trans_id_q;
    logic [issue_pkg::XLEN-1:0]          result_q;

    always_comb begin
        case (req_i.op)
            issue_pkg::ADD: result = req_i.operand_a + req_i.operand_b;
            issue_pkg::SUB: result = req_i.operand_a - req_i.operand_b;
            issue_pkg::AND: result = req_i.operand_a & req_i.operand_b;
            issue_pkg::OR:  result = req_i.operand_a | req_i.operand_b;
            issue_pkg::XOR: result = req_i.operand_a ^ req_i.operand_b;
            // shift amount is the low five bits
            issue_pkg::SLL: result = req_i.operand_a << req_i.operand_b[4:0];
            default:        result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_i.valid && !flush_i;
        end
    end

    always_ff @(posedge clk_i) begin
        trans_id_q <= req_i.trans_id;
        result_q   <= result;
    end

    assign wb_o = '{valid: valid_q, trans_id: trans_id_q, result: result_q};

endmodule

// File: verilog/commit_unit.sv
// retires at most one instruction per cycle, always the oldest
`timescale 1ns/1ps

module commit_unit (
    input  issue_pkg::sb_entry_t       head_i,
    input  logic                       head_issued_i,
    output logic                       commit_ack_o,
    output logic                       rf_we_o,
    output logic [4:0]                 rf_waddr_o,
    output logic [issue_pkg::XLEN-1:0] rf_wdata_o,
    output logic                       commit_valid_o,
    output issue_pkg::commit_t         commit_o
);

    // head retires as soon as its result is back
    assign commit_ack_o = head_issued_i && head_i.valid;

    // register file write at the same edge that frees the slot
    assign rf_we_o    = commit_ack_o;
    assign rf_waddr_o = head_i.instr.rd;
    assign rf_wdata_o = head_i.result;

    assign commit_valid_o = commit_ack_o;
    assign commit_o       = '{rd: head_i.instr.rd, result: head_i.result};

endmodule

// File: verilog/issue_pkg.sv
// NR_ENTRIES must stay a power of two so the slot pointers wrap for free, XLEN is fixed at 32
package issue_pkg;

    // --------------------
    // sizes
    // --------------------
    localparam int XLEN          = 32;
    localparam int NR_ENTRIES    = 4;
    localparam int TRANS_ID_BITS = $clog2(NR_ENTRIES);
    // port 0 is the alu, port 1 the multiplier
    localparam int NR_WB_PORTS   = 2;
    localparam int MUL_STAGES    = 3;

    // unit that owns a destination register
    typedef enum logic [1:0] {
        FU_NONE,
        FU_ALU,
        FU_MUL
    } fu_t;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        MUL
    } alu_op_t;

    // --------------------
    // records
    // --------------------
    typedef struct packed {
        fu_t             fu;
        alu_op_t         op;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic            use_imm;
        logic [XLEN-1:0] imm;
    } instr_t;

    typedef struct packed {
        instr_t                   instr;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        // result has been written back
        logic                     valid;
    } sb_entry_t;

    typedef struct packed {
        logic                     valid;
        alu_op_t                  op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_req_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
    } wb_t;

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] result;
    } commit_t;

endpackage

// File: verilog/issue_subsystem.sv
// decode input holds until ack, commit output is a strobe with no back-pressure
`timescale 1ns/1ps

module issue_subsystem (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  logic               decoded_valid_i,
    input  issue_pkg::instr_t  decoded_instr_i,
    output logic               decoded_ack_o,
    output logic               full_o,
    output logic               commit_valid_o,
    output issue_pkg::commit_t commit_o
);

    issue_pkg::sb_entry_t                        issue_entry;
    logic                                        issue_valid;
    logic                                        issue_ack;
    issue_pkg::wb_t [issue_pkg::NR_WB_PORTS-1:0] wb;
    logic [4:0]                                  rs1_addr;
    logic [4:0]                                  rs2_addr;
    logic [issue_pkg::XLEN-1:0]                  fwd_rs1;
    logic                                        fwd_rs1_valid;
    logic [issue_pkg::XLEN-1:0]                  fwd_rs2;
    logic                                        fwd_rs2_valid;
    issue_pkg::fu_t [31:0]                       rd_clobber;
    logic [issue_pkg::XLEN-1:0]                  rf_rdata_a;
    logic [issue_pkg::XLEN-1:0]                  rf_rdata_b;
    issue_pkg::sb_entry_t                        head_entry;
    logic                                        head_issued;
    logic                                        commit_ack;
    logic                                        rf_we;
    logic [4:0]                                  rf_waddr;
    logic [issue_pkg::XLEN-1:0]                  rf_wdata;
    issue_pkg::fu_req_t                          alu_req;
    issue_pkg::fu_req_t                          mul_req;

    // decode is acknowledged in the issue cycle
    assign decoded_ack_o = issue_ack;

    scoreboard scoreboard0 (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .decoded_valid_i (decoded_valid_i),
        .decoded_instr_i (decoded_instr_i),
        .issue_instr_o   (issue_entry),
        .issue_valid_o   (issue_valid),
        .issue_ack_i     (issue_ack),
        .wb_i            (wb),
        .rs1_i           (rs1_addr),
        .rs2_i           (rs2_addr),
        .rs1_o           (fwd_rs1),
        .rs1_valid_o     (fwd_rs1_valid),
        .rs2_o           (fwd_rs2),
        .rs2_valid_o     (fwd_rs2_valid),
        .rd_clobber_o    (rd_clobber),
        .commit_instr_o  (head_entry),
        .head_issued_o   (head_issued),
        .commit_ack_i    (commit_ack),
        .full_o          (full_o)
    );

    operand_read operand_read0 (
        .issue_instr_i   (issue_entry),
        .issue_valid_i   (issue_valid),
        .rd_clobber_i    (rd_clobber),
        .fwd_rs1_i       (fwd_rs1),
        .fwd_rs1_valid_i (fwd_rs1_valid),
        .fwd_rs2_i       (fwd_rs2),
        .fwd_rs2_valid_i (fwd_rs2_valid),
        .rf_rdata_a_i    (rf_rdata_a),
        .rf_rdata_b_i    (rf_rdata_b),
        .rs1_o           (rs1_addr),
        .rs2_o           (rs2_addr),
        .issue_ack_o     (issue_ack),
        .alu_req_o       (alu_req),
        .mul_req_o       (mul_req)
    );

    regfile regfile0 (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (rs1_addr),
        .raddr_b_i (rs2_addr),
        .rdata_a_o (rf_rdata_a),
        .rdata_b_o (rf_rdata_b),
        .we_i      (rf_we),
        .waddr_i   (rf_waddr),
        .wdata_i   (rf_wdata)
    );

    // write-back port 0
    alu_unit alu_unit0 (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .req_i   (alu_req),
        .wb_o    (wb[0])
    );

    // write-back port 1
    mul_unit mul_unit0 (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .req_i   (mul_req),
        .wb_o    (wb[1])
    );

    commit_unit commit_unit0 (
        .head_i         (head_entry),
        .head_issued_i  (head_issued),
        .commit_ack_o   (commit_ack),
        .rf_we_o        (rf_we),
        .rf_waddr_o     (rf_waddr),
        .rf_wdata_o     (rf_wdata),
        .commit_valid_o (commit_valid_o),
        .commit_o       (commit_o)
    );

endmodule

// File: verilog/mul_unit.sv
// fixed MUL_STAGES latency, low XLEN bits of the product only, op is not decoded
`timescale 1ns/1ps

module mul_unit (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  issue_pkg::fu_req_t req_i,
    output issue_pkg::wb_t     wb_o
);

    logic [issue_pkg::MUL_STAGES-1:0]    valid_q;
    logic [issue_pkg::TRANS_ID_BITS-1:0] trans_id_q [issue_pkg::MUL_STAGES];
    // stage 0 holds operands, later stages hold the product
    logic [issue_pkg::XLEN-1:0]          op_a_q;
    logic [issue_pkg::XLEN-1:0]          op_b_q;
    logic [issue_pkg::XLEN-1:0]          prod_q [1:issue_pkg::MUL_STAGES-1];

    // --------------------
    // valid chain
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            // drop everything in flight
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[issue_pkg::MUL_STAGES-2:0], req_i.valid};
        end
    end

    // --------------------
    // datapath
    // --------------------
    always_ff @(posedge clk_i) begin
        op_a_q        <= req_i.operand_a;
        op_b_q        <= req_i.operand_b;
        trans_id_q[0] <= req_i.trans_id;
        prod_q[1]     <= op_a_q * op_b_q;
        for (int s = 1; s < issue_pkg::MUL_STAGES; s++) begin
            trans_id_q[s] <= trans_id_q[s-1];
        end
        for (int s = 2; s < issue_pkg::MUL_STAGES; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
    end

    assign wb_o = '{valid:    valid_q[issue_pkg::MUL_STAGES-1],
                    trans_id: trans_id_q[issue_pkg::MUL_STAGES-1],
                    result:   prod_q[issue_pkg::MUL_STAGES-1]};

endmodule

// File: verilog/operand_read.sv
// an instruction whose fu is FU_NONE issues but never writes back and so blocks commit
`timescale 1ns/1ps

module operand_read (
    input  issue_pkg::sb_entry_t       issue_instr_i,
    input  logic                       issue_valid_i,
    input  issue_pkg::fu_t [31:0]      rd_clobber_i,
    // forwarded operands from the scoreboard
    input  logic [issue_pkg::XLEN-1:0] fwd_rs1_i,
    input  logic                       fwd_rs1_valid_i,
    input  logic [issue_pkg::XLEN-1:0] fwd_rs2_i,
    input  logic                       fwd_rs2_valid_i,
    // register file read data
    input  logic [issue_pkg::XLEN-1:0] rf_rdata_a_i,
    input  logic [issue_pkg::XLEN-1:0] rf_rdata_b_i,
    output logic [4:0]                 rs1_o,
    output logic [4:0]                 rs2_o,
    output logic                       issue_ack_o,
    output issue_pkg::fu_req_t         alu_req_o,
    output issue_pkg::fu_req_t         mul_req_o
);

    logic               rs1_busy;
    logic               rs2_busy;
    logic               rs1_ready;
    logic               rs2_ready;
    logic               rd_free;
    issue_pkg::fu_req_t req;

    // same addresses feed the scoreboard lookup and the register file
    assign rs1_o = issue_instr_i.instr.rs1;
    assign rs2_o = issue_instr_i.instr.rs2;

    // --------------------
    // hazard check
    // --------------------
    assign rs1_busy  = (rd_clobber_i[rs1_o] != issue_pkg::FU_NONE);
    assign rs2_busy  = (rd_clobber_i[rs2_o] != issue_pkg::FU_NONE);
    // a pending producer is fine once its result sits in the scoreboard
    assign rs1_ready = !rs1_busy || fwd_rs1_valid_i;
    assign rs2_ready = issue_instr_i.instr.use_imm || !rs2_busy || fwd_rs2_valid_i;
    // waw: only one in-flight writer per register
    assign rd_free   = (rd_clobber_i[issue_instr_i.instr.rd] == issue_pkg::FU_NONE);

    assign issue_ack_o = issue_valid_i && rs1_ready && rs2_ready && rd_free;

    // --------------------
    // operand select and dispatch
    // --------------------
    always_comb begin
        req.valid     = 1'b0;
        req.op        = issue_instr_i.instr.op;
        req.trans_id  = issue_instr_i.trans_id;
        req.operand_a = rs1_busy ? fwd_rs1_i : rf_rdata_a_i;
        if (issue_instr_i.instr.use_imm) begin
            req.operand_b = issue_instr_i.instr.imm;
        end else begin
            req.operand_b = rs2_busy ? fwd_rs2_i : rf_rdata_b_i;
        end

        alu_req_o       = req;
        alu_req_o.valid = issue_ack_o && (issue_instr_i.instr.fu == issue_pkg::FU_ALU);
        mul_req_o       = req;
        mul_req_o.valid = issue_ack_o && (issue_instr_i.instr.fu == issue_pkg::FU_MUL);
    end

endmodule

// File: verilog/regfile.sv
// reads are combinational, writes to x0 are dropped
`timescale 1ns/1ps

module regfile (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [4:0]                 raddr_a_i,
    input  logic [4:0]                 raddr_b_i,
    output logic [issue_pkg::XLEN-1:0] rdata_a_o,
    output logic [issue_pkg::XLEN-1:0] rdata_b_o,
    input  logic                       we_i,
    input  logic [4:0]                 waddr_i,
    input  logic [issue_pkg::XLEN-1:0] wdata_i
);

    logic [issue_pkg::XLEN-1:0] regs_q [32];

    // x0 is never written and keeps its reset value of zero
    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int r = 0; r < 32; r++) begin
                regs_q[r] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

endmodule

// File: verilog/scoreboard.sv
// slot index is the transaction id, no issue is offered while flush_i is high
`timescale 1ns/1ps

module scoreboard (
    input  logic                                       clk_i,
    input  logic                                       rst_ni,
    input  logic                                       flush_i,
    // decode side
    input  logic                                       decoded_valid_i,
    input  issue_pkg::instr_t                          decoded_instr_i,
    // operand read side
    output issue_pkg::sb_entry_t                       issue_instr_o,
    output logic                                       issue_valid_o,
    input  logic                                       issue_ack_i,
    // write-back ports
    input  issue_pkg::wb_t [issue_pkg::NR_WB_PORTS-1:0] wb_i,
    // forwarding lookup
    input  logic [4:0]                                 rs1_i,
    input  logic [4:0]                                 rs2_i,
    output logic [issue_pkg::XLEN-1:0]                 rs1_o,
    output logic                                       rs1_valid_o,
    output logic [issue_pkg::XLEN-1:0]                 rs2_o,
    output logic                                       rs2_valid_o,
    output issue_pkg::fu_t [31:0]                      rd_clobber_o,
    // commit side
    output issue_pkg::sb_entry_t                       commit_instr_o,
    output logic                                       head_issued_o,
    input  logic                                       commit_ack_i,
    output logic                                       full_o
);

    logic [issue_pkg::NR_ENTRIES-1:0]    issued_q, issued_d;
    issue_pkg::sb_entry_t                entry_q [issue_pkg::NR_ENTRIES];
    issue_pkg::sb_entry_t                entry_d [issue_pkg::NR_ENTRIES];
    logic [issue_pkg::TRANS_ID_BITS-1:0] issue_ptr_q, issue_ptr_d;
    logic [issue_pkg::TRANS_ID_BITS-1:0] commit_ptr_q, commit_ptr_d;
    // one extra bit so a full ring is distinguishable from empty
    logic [issue_pkg::TRANS_ID_BITS:0]   cnt_q, cnt_d;

    assign full_o = (cnt_q == issue_pkg::NR_ENTRIES);

    // head of the ring goes straight to commit
    assign commit_instr_o = entry_q[commit_ptr_q];
    assign head_issued_o  = issued_q[commit_ptr_q];

    // issue pointer doubles as the transaction id
    always_comb begin
        issue_instr_o          = '0;
        issue_instr_o.instr    = decoded_instr_i;
        issue_instr_o.trans_id = issue_ptr_q;
        issue_valid_o          = decoded_valid_i && !full_o && !flush_i;
    end

    // --------------------
    // ring update
    // --------------------
    always_comb begin : ring_next
        issued_d     = issued_q;
        entry_d      = entry_q;
        issue_ptr_d  = issue_ptr_q;
        commit_ptr_d = commit_ptr_q;

        if (issue_ack_i) begin
            issued_d[issue_ptr_q] = 1'b1;
            entry_d[issue_ptr_q]  = issue_instr_o;
            issue_ptr_d           = issue_ptr_q + 1'b1;
        end

        // slot is free again once retired
        if (commit_ack_i) begin
            issued_d[commit_ptr_q] = 1'b0;
            commit_ptr_d           = commit_ptr_q + 1'b1;
        end

        cnt_d = cnt_q + {{issue_pkg::TRANS_ID_BITS{1'b0}}, issue_ack_i}
                      - {{issue_pkg::TRANS_ID_BITS{1'b0}}, commit_ack_i};

        // results land on their own slot
        for (int p = 0; p < issue_pkg::NR_WB_PORTS; p++) begin
            if (wb_i[p].valid) begin
                entry_d[wb_i[p].trans_id].valid  = 1'b1;
                entry_d[wb_i[p].trans_id].result = wb_i[p].result;
            end
        end

        // flush wins over everything above
        if (flush_i) begin
            issued_d     = '0;
            issue_ptr_d  = '0;
            commit_ptr_d = '0;
            cnt_d        = '0;
        end
    end

    // --------------------
    // clobber table
    // --------------------
    always_comb begin : clobber
        rd_clobber_o = '{default: issue_pkg::FU_NONE};
        for (int i = 0; i < issue_pkg::NR_ENTRIES; i++) begin
            // x0 never has an owner
            if (issued_q[i] && entry_q[i].instr.rd != 5'd0) begin
                rd_clobber_o[entry_q[i].instr.rd] = entry_q[i].instr.fu;
            end
        end
    end

    // --------------------
    // forwarding
    // --------------------
    // waw stall keeps at most one issued owner per register
    always_comb begin : forward
        rs1_o       = '0;
        rs1_valid_o = 1'b0;
        rs2_o       = '0;
        rs2_valid_o = 1'b0;
        for (int i = 0; i < issue_pkg::NR_ENTRIES; i++) begin
            if (issued_q[i] && entry_q[i].instr.rd == rs1_i) begin
                rs1_o       = entry_q[i].result;
                rs1_valid_o = entry_q[i].valid;
            end
            if (issued_q[i] && entry_q[i].instr.rd == rs2_i) begin
                rs2_o       = entry_q[i].result;
                rs2_valid_o = entry_q[i].valid;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            issued_q     <= '0;
            issue_ptr_q  <= '0;
            commit_ptr_q <= '0;
            cnt_q        <= '0;
        end else begin
            issued_q     <= issued_d;
            issue_ptr_q  <= issue_ptr_d;
            commit_ptr_q <= commit_ptr_d;
            cnt_q        <= cnt_d;
        end
    end

    // slot payloads and write-back results
    always_ff @(posedge clk_i) begin
        entry_q <= entry_d;
    end

endmodule
